//--- vlog.f
+incdir+source
+incdir+tb
source/rv_pkg.sv
source/rv_stall_reg.sv
source/rv_regfile.sv
source/rv_decoder.sv
source/rv_hazard_unit.sv
source/rv_alu.sv
source/rv_core.sv
tb/tb_rv_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ns -j 0
TOP       := tb_rv_core
FILELIST  := vlog.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) source/rv_defines.svh tb/tb_rv_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	cat $(LOG)
	@! grep -q "CHECKS FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic [31:0] lfsr_state;
    int          prog_words;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Initial data memory contents
    function automatic rv_pkg::word_t fill_word(input int i);
        return (rv_pkg::word_t'(i) * 32'h9e37_79b1) ^ 32'hc3a5_0f0f;
    endfunction

    function automatic rv_pkg::word_t r_word(input logic alt, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic rv_pkg::word_t i_word(input logic [6:0] opcode, input logic [11:0] imm,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic rv_pkg::word_t s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    // Result of an OP or OP-IMM instruction per the ISA
    function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          n;
        lfsr_state = 32'hf562;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = `RV_NOP;
        end
        n = 0;
        while (n < PROG_LEN) begin
            kind = 3'(rand_bits(3));
            rd   = {2'b0, 3'(rand_bits(3))}; // x0..x7 only
            rs1  = {2'b0, 3'(rand_bits(3))};
            rs2  = {2'b0, 3'(rand_bits(3))};
            f3   = 3'(rand_bits(3));
            case (kind)
                3'd0, 3'd1: begin
                    imem[n] = r_word((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1) != 0,
                                     rs2, rs1, f3, rd);
                end
                3'd2, 3'd3: begin
                    if (f3 == 3'b001) begin
                        imm = {7'b0, 5'(rand_bits(5))};
                    end else if (f3 == 3'b101) begin
                        imm = {1'b0, 1'(rand_bits(1)), 5'b0, 5'(rand_bits(5))};
                    end else begin
                        imm = 12'(rand_bits(12));
                    end
                    imem[n] = i_word(`RV_OP_IMM, imm, rs1, f3, rd);
                end
                3'd4: imem[n] = {20'(rand_bits(20)), rd, `RV_OP_LUI};
                3'd5: imem[n] = i_word(`RV_OP_LOAD, {4'b0, 6'(rand_bits(6)), 2'b0}, 5'd0, 3'b010, rd);
                3'd6: imem[n] = s_word({4'b0, 6'(rand_bits(6)), 2'b0}, rs2, 5'd0);
                default: begin
                    // Load with its result used by the very next instruction
                    imem[n] = i_word(`RV_OP_LOAD, {4'b0, 6'(rand_bits(6)), 2'b0}, 5'd0, 3'b010, rd);
                    n++;
                    if (rand_bits(1) != 0) begin
                        imem[n] = r_word(1'b0, rs2, rd, f3, rs1);
                    end else begin
                        imem[n] = s_word({4'b0, 6'(rand_bits(6)), 2'b0}, rd, 5'd0);
                    end
                end
            endcase
            n++;
        end
        for (int k = 1; k < 8; k++) begin
            imem[n] = s_word(12'(12'h100 + 4 * k), 5'(k), 5'd0); // Dump x1..x7
            n++;
        end
        prog_words = n;
    endtask

    // Runs the program in order and queues the expected stores
    task automatic run_model();
        rv_pkg::word_t regs [32];
        rv_pkg::word_t mem [DMEM_WORDS];
        rv_pkg::word_t w;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t addr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        for (int p = 0; p < prog_words; p++) begin
            w = imem[p];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            case (w[6:0])
                `RV_OP_REG: regs[w[11:7]] = ref_alu(w[14:12], w[30], a, b);
                `RV_OP_IMM: begin
                    regs[w[11:7]] = ref_alu(w[14:12], w[14:12] == 3'b101 && w[30], a,
                                            {{20{w[31]}}, w[31:20]});
                end
                `RV_OP_LUI: regs[w[11:7]] = {w[31:12], 12'b0};
                `RV_OP_LOAD: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    regs[w[11:7]] = mem[addr[7:2]];
                    exp_loads++;
                end
                `RV_OP_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(b);
                    if (addr < 32'd256) begin
                        mem[addr[7:2]] = b;
                    end
                end
                default: ;
            endcase
            regs[0] = '0;
        end
        exp_total = exp_addr_q.size();
    endtask

`endif

//--- tb/tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_rv_core;

    localparam int PROG_LEN   = 200;
    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 64;
    localparam int RUN_LIMIT  = 2000;

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t instr_data;
    rv_pkg::word_t mem_rdata;
    rv_pkg::word_t instr_addr;
    rv_pkg::word_t mem_addr;
    rv_pkg::word_t mem_wdata;
    logic          mem_we;
    logic          mem_re;

    rv_pkg::word_t imem [IMEM_WORDS];
    rv_pkg::word_t dmem [DMEM_WORDS];
    rv_pkg::word_t exp_addr_q [$];
    rv_pkg::word_t exp_data_q [$];
    int            exp_total;
    int            exp_loads;
    int            loads_seen;
    int            stores_seen;
    int            store_errors;
    int            fetch_errors;
    int            flag_errors;
    int            other_errors;
    int            cycles_after_reset;
    int            stall_count;
    rv_pkg::word_t last_fetch;
    logic          last_was_repeat;
    logic          fetch_started;

    `include "tb_rv_model.svh"

    rv_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_data_i (instr_data),
        .mem_rdata_i  (mem_rdata),
        .instr_addr_o (instr_addr),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .mem_re_o     (mem_re)
    );

    always #50 clk = ~clk;

    function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
        rv_pkg::word_t offset;
        offset = addr - `RV_RESET_PC;
        if (offset[1:0] != 2'b0 || offset >= IMEM_WORDS * 4) begin
            return `RV_NOP;
        end
        return imem[offset[10:2]];
    endfunction

    // Memories answer from the addresses set up at the edge
    always @(posedge clk) begin
        #1;
        instr_data = fetch_word(instr_addr);
        mem_rdata  = mem_re ? dmem[mem_addr[7:2]] : '0; // Nothing unless reading
    end

    always @(posedge clk) begin
        if (rst_n && mem_we && mem_addr < 32'd256) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    task automatic check_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
        rv_pkg::word_t exp_addr;
        rv_pkg::word_t exp_data;
        stores_seen++;
        if (exp_addr_q.size() == 0) begin
            $display("store number %0d came after the last expected store", stores_seen);
            store_errors++;
            return;
        end
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        if (addr !== exp_addr) begin
            $display("error mem_addr_o got %h expected %h", addr, exp_addr);
            store_errors++;
        end
        if (data !== exp_data) begin
            $display("error mem_wdata_o got %h expected %h", data, exp_data);
            store_errors++;
        end
    endtask

    // One repeat per stall and never two in a row
    task automatic check_fetch(input rv_pkg::word_t addr);
        if (!fetch_started) begin
            fetch_started = 1'b1;
            if (addr !== `RV_RESET_PC) begin
                $display("error instr_addr_o got %h expected %h", addr, `RV_RESET_PC);
                fetch_errors++;
            end
        end else if (addr === last_fetch && !last_was_repeat) begin
            last_was_repeat = 1'b1;
            stall_count++;
        end else if (addr === last_fetch + 32'd4) begin
            last_was_repeat = 1'b0;
        end else begin
            $display("error instr_addr_o got %h expected %h", addr, last_fetch + 32'd4);
            fetch_errors++;
            last_was_repeat = 1'b0;
        end
        last_fetch = addr;
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            flag_errors++;
        end
    endtask

    // Outputs are settled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_fetch(instr_addr);
            if (cycles_after_reset < 3) begin // First access reaches the port in cycle 3
                check_flag("mem_we_o", mem_we, 1'b0);
                check_flag("mem_re_o", mem_re, 1'b0);
            end
            if (mem_we) begin
                check_store(mem_addr, mem_wdata);
            end
            if (mem_re) begin
                loads_seen++;
            end
            cycles_after_reset++;
        end
    end

    initial begin
        int wait_cycles;
        clk                = 1'b0;
        rst_n              = 1'b0;
        instr_data         = `RV_NOP;
        mem_rdata          = '0;
        exp_loads          = 0;
        loads_seen         = 0;
        stores_seen        = 0;
        store_errors       = 0;
        fetch_errors       = 0;
        flag_errors        = 0;
        other_errors       = 0;
        cycles_after_reset = 0;
        stall_count        = 0;
        last_fetch         = '0;
        last_was_repeat    = 1'b0;
        fetch_started      = 1'b0;
        build_program();
        run_model();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        wait_cycles = 0;
        while (stores_seen < exp_total && wait_cycles < RUN_LIMIT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (stores_seen < exp_total) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     wait_cycles, stores_seen, exp_total);
            other_errors++;
        end
        repeat (20) @(posedge clk); // Trailing NOPs let any extra store show up
        if (stall_count == 0) begin
            $display("no load-use stall showed up on the fetch address");
            other_errors++;
        end
        if (loads_seen != exp_loads) begin
            $display("mem_re_o was high in %0d cycles but the program has %0d loads",
                     loads_seen, exp_loads);
            other_errors++;
        end

        $display("errors: store %0d, fetch %0d, flag %0d, other %0d",
                 store_errors, fetch_errors, flag_errors, other_errors);
        if (store_errors + fetch_errors + flag_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t instr_data_i,
    input  rv_pkg::word_t mem_rdata_i,
    output rv_pkg::word_t instr_addr_o,
    output rv_pkg::word_t mem_addr_o,
    output rv_pkg::word_t mem_wdata_o,
    output logic          mem_we_o,
    output logic          mem_re_o
);

    localparam rv_pkg::if_id_t IF_ID_NOP = '{instr: `RV_NOP, pc: `RV_RESET_PC};
    localparam rv_pkg::id_ex_t ID_EX_NOP = '0; // No enables and an ADD of zeros

    rv_pkg::word_t     pc;
    rv_pkg::if_id_t    if_id_d;
    rv_pkg::if_id_t    if_id_q;
    rv_pkg::id_ex_t    id_ctrl;
    rv_pkg::id_ex_t    id_ex_d;
    rv_pkg::id_ex_t    id_ex_q;
    rv_pkg::ex_mem_t   ex_mem_q;
    rv_pkg::mem_wb_t   mem_wb_q;
    rv_pkg::word_t     wb_result_q;
    rv_pkg::reg_addr_t wb_rd_q;
    logic              wb_we_q;
    rv_pkg::reg_addr_t id_rs1;
    rv_pkg::reg_addr_t id_rs2;
    rv_pkg::word_t     rf_rs1_data;
    rv_pkg::word_t     rf_rs2_data;
    rv_pkg::fwd_sel_e  fwd_a;
    rv_pkg::fwd_sel_e  fwd_b;
    logic              stall;
    rv_pkg::word_t     opnd_a;
    rv_pkg::word_t     opnd_b;
    rv_pkg::word_t     alu_a;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     alu_result;

    // Fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign if_id_d = '{instr: instr_data_i, pc: pc};

    rv_stall_reg #(
        .T               (rv_pkg::if_id_t),
        .BUBBLE          (IF_ID_NOP),
        .BUBBLE_ON_STALL (1'b0)
    ) u_if_id (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (stall),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    // Decode
    rv_decoder u_decoder (
        .instr_i (if_id_q.instr),
        .rs1_o   (id_rs1),
        .rs2_o   (id_rs2),
        .ctrl_o  (id_ctrl)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (id_rs1),
        .rs2_i      (id_rs2),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .rd_i       (mem_wb_q.rd),
        .rd_data_i  (mem_wb_q.result),
        .rd_we_i    (mem_wb_q.reg_we)
    );

    always_comb begin
        id_ex_d          = id_ctrl;
        id_ex_d.rs1_data = rf_rs1_data;
        id_ex_d.rs2_data = rf_rs2_data;
    end

    rv_stall_reg #(
        .T               (rv_pkg::id_ex_t),
        .BUBBLE          (ID_EX_NOP),
        .BUBBLE_ON_STALL (1'b1)
    ) u_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (stall),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    rv_hazard_unit u_hazard (
        .id_rs1_i (id_rs1),
        .id_rs2_i (id_rs2),
        .ex_i     (id_ex_q),
        .ex_mem_i (ex_mem_q),
        .mem_wb_i (mem_wb_q),
        .wb_rd_i  (wb_rd_q),
        .wb_we_i  (wb_we_q),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b),
        .stall_o  (stall)
    );

    // Execute
    function automatic rv_pkg::word_t fwd_value(input rv_pkg::fwd_sel_e sel,
                                                input rv_pkg::word_t rf_value);
        case (sel)
            rv_pkg::FWD_EX_MEM: return ex_mem_q.result;
            rv_pkg::FWD_MEM_WB: return mem_wb_q.result;
            rv_pkg::FWD_WB:     return wb_result_q;
            default:            return rf_value;
        endcase
    endfunction

    always_comb begin
        opnd_a = fwd_value(fwd_a, id_ex_q.rs1_data);
        opnd_b = fwd_value(fwd_b, id_ex_q.rs2_data);
    end

    assign alu_a = id_ex_q.is_lui ? '0 : opnd_a; // LUI is 0 + imm
    assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : opnd_b;

    rv_alu u_alu (
        .op_i     (id_ex_q.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.result     <= alu_result;
            ex_mem_q.store_data <= opnd_b; // Forwarded rs2
            ex_mem_q.rd         <= id_ex_q.rd;
            ex_mem_q.mem_we     <= id_ex_q.mem_we;
            ex_mem_q.mem_re     <= id_ex_q.mem_re;
            ex_mem_q.reg_we     <= id_ex_q.reg_we;
        end
    end

    // Read data arrives in the same cycle as the address
    assign mem_addr_o  = ex_mem_q.result;
    assign mem_wdata_o = ex_mem_q.store_data;
    assign mem_we_o    = ex_mem_q.mem_we;
    assign mem_re_o    = ex_mem_q.mem_re;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.result <= ex_mem_q.mem_re ? mem_rdata_i : ex_mem_q.result;
            mem_wb_q.rd     <= ex_mem_q.rd;
            mem_wb_q.reg_we <= ex_mem_q.reg_we;
        end
    end

    // Copy of the last retired write for the operand bypass
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_q <= 1'b0;
            wb_rd_q <= '0;
        end else begin
            wb_we_q <= mem_wb_q.reg_we;
            wb_rd_q <= mem_wb_q.rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_result_q <= mem_wb_q.result;
    end

    assign instr_addr_o = pc;

    a_mem_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_we_o && mem_re_o));

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    output rv_pkg::word_t   result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            rv_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_pkg::ALU_AND:  result_o = a_i & b_i;
            default:          result_o = '0;
        endcase
    end

endmodule

//--- source/rv_hazard_unit.sv
`timescale 1ns/1ns

module rv_hazard_unit (
    input  rv_pkg::reg_addr_t id_rs1_i,
    input  rv_pkg::reg_addr_t id_rs2_i,
    input  rv_pkg::id_ex_t    ex_i,
    input  rv_pkg::ex_mem_t   ex_mem_i,
    input  rv_pkg::mem_wb_t   mem_wb_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  logic              wb_we_i,
    output rv_pkg::fwd_sel_e  fwd_a_o,
    output rv_pkg::fwd_sel_e  fwd_b_o,
    output logic              stall_o
);

    // Nearest older writer wins
    function automatic rv_pkg::fwd_sel_e fwd_sel(input rv_pkg::reg_addr_t rs,
                                                 input logic used);
        rv_pkg::fwd_sel_e sel;
        sel = rv_pkg::FWD_NONE;
        if (used && rs != '0) begin
            // Load data is not back yet while the load sits in EX/MEM
            if (ex_mem_i.reg_we && !ex_mem_i.mem_re && ex_mem_i.rd == rs) begin
                sel = rv_pkg::FWD_EX_MEM;
            end else if (mem_wb_i.reg_we && mem_wb_i.rd == rs) begin
                sel = rv_pkg::FWD_MEM_WB;
            end else if (wb_we_i && wb_rd_i == rs) begin
                sel = rv_pkg::FWD_WB; // Written last edge, missed by the ID read
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = fwd_sel(ex_i.rs1, ex_i.uses_rs1);
        fwd_b_o = fwd_sel(ex_i.rs2, ex_i.uses_rs2);
    end

    // Load in EX feeding the instruction right behind it
    assign stall_o = ex_i.mem_re && ex_i.rd != '0 &&
                     (ex_i.rd == id_rs1_i || ex_i.rd == id_rs2_i);

endmodule

//--- source/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_decoder (
    input  rv_pkg::word_t     instr_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::id_ex_t    ctrl_o
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic          alt_reg;
    logic          alt_imm;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_u;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    // SUB and SRA only; SRAI is the sole immediate form with the alternate bit
    assign alt_reg = instr_i[30] && (funct3 == 3'b000 || funct3 == 3'b101);
    assign alt_imm = instr_i[30] && (funct3 == 3'b101);

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        ctrl_o    = '0; // Unknown opcodes fall through as a NOP
        ctrl_o.rd = instr_i[11:7];
        case (opcode)
            `RV_OP_REG: begin
                ctrl_o.alu_op   = rv_pkg::alu_op_e'({alt_reg, funct3});
                ctrl_o.rs1      = rs1_o;
                ctrl_o.rs2      = rs2_o;
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.uses_rs2 = 1'b1;
                ctrl_o.reg_we   = 1'b1;
            end
            `RV_OP_IMM: begin
                ctrl_o.alu_op   = rv_pkg::alu_op_e'({alt_imm, funct3});
                ctrl_o.imm      = imm_i;
                ctrl_o.rs1      = rs1_o;
                ctrl_o.use_imm  = 1'b1;
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.reg_we   = 1'b1;
            end
            `RV_OP_LOAD: begin
                ctrl_o.alu_op   = rv_pkg::ALU_ADD; // Address calculation
                ctrl_o.imm      = imm_i;
                ctrl_o.rs1      = rs1_o;
                ctrl_o.use_imm  = 1'b1;
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.mem_re   = 1'b1;
                ctrl_o.reg_we   = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl_o.alu_op   = rv_pkg::ALU_ADD;
                ctrl_o.imm      = imm_s;
                ctrl_o.rs1      = rs1_o;
                ctrl_o.rs2      = rs2_o; // Store data, not an ALU operand
                ctrl_o.use_imm  = 1'b1;
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.uses_rs2 = 1'b1;
                ctrl_o.mem_we   = 1'b1;
                ctrl_o.rd       = '0;
            end
            `RV_OP_LUI: begin
                ctrl_o.alu_op  = rv_pkg::ALU_ADD;
                ctrl_o.imm     = imm_u;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.is_lui  = 1'b1;
                ctrl_o.reg_we  = 1'b1;
            end
            default: begin
                ctrl_o.rd = '0;
            end
        endcase
    end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     rd_data_i,
    input  logic              rd_we_i
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && rd_i != '0) begin // x0 stays zero
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- source/rv_stall_reg.sv
`timescale 1ns/1ns

module rv_stall_reg #(
    parameter type T               = rv_pkg::word_t,
    parameter T    BUBBLE          = T'(0),
    parameter bit  BUBBLE_ON_STALL = 1'b0 // 0 holds on stall, 1 inserts the bubble
) (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= BUBBLE;
        end else if (stall_i) begin
            if (BUBBLE_ON_STALL) begin
                q_o <= BUBBLE;
            end
        end else begin
            q_o <= d_i;
        end
    end

    // A load-use stall always drains in one cycle
    a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> !stall_i);

endmodule

//--- source/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    // Operand source picked by the forwarding logic
    typedef enum logic [1:0] {
        FWD_NONE   = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2,
        FWD_WB     = 2'd3
    } fwd_sel_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      mem_we;
        logic      mem_re;
        logic      reg_we;
        logic      is_lui;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      mem_we;
        logic      mem_re;
        logic      reg_we;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      reg_we;
    } mem_wb_t;

endpackage

//--- source/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath widths
`define RV_XLEN     32
`define RV_REG_AW   5

`define RV_RESET_PC 32'h8000_0000
`define RV_NOP      32'h0000_0013 // addi x0, x0, 0

// Opcodes of the supported subset
`define RV_OP_REG   7'b0110011
`define RV_OP_IMM   7'b0010011
`define RV_OP_LOAD  7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_LUI   7'b0110111

`endif
